/* lab_board.f */
src/board_pkg.sv
src/alu_pkg.sv
src/mode_reg.sv
src/alu4.sv
src/prio_encoder.sv
src/shift_rng.sv
src/seg_decoder.sv
src/display_mux.sv
src/lab_board.sv
dv/lab_board_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := lab_board_tb
FILELIST  := lab_board.f
FLAGS     := --binary --timing --assert
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* dv/lab_board_tb.sv */
`timescale 1ns/1ps

module lab_board_tb;
    import board_pkg::*;
    import alu_pkg::*;

    logic        btn;
    logic        rst_n;
    logic [15:0] sw;
    logic [15:0] ledr;
    seg_bank_t   segs;

    // reference state built from the switch rules
    board_mode_e exp_mode;
    logic [7:0]  exp_pattern;
    logic [6:0]  exp_alu;
    logic [12:0] exp_enc;
    seg_t        exp_enc_seg;

    lab_board DUT (
        .btn   (btn),
        .rst_n (rst_n),
        .sw    (sw),
        .ledr  (ledr),
        .segs  (segs)
    );

    always #50 btn = ~btn;

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t: %s", $time, what);
        $display("Something failed");
        $fatal(1, "check failed");
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("Something failed");
        $fatal(1, "wait timed out");
    endtask

    // {carry, ovfl, zero, result}
    function automatic logic [6:0] alu_leds(input logic [15:0] s);
        int         a;
        int         b;
        int         sa;
        int         sb;
        int         full;
        int         sfull;
        logic [3:0] res;
        logic       carry;
        logic       ovfl;
        a     = int'(s[3:0]);
        b     = int'(s[7:4]);
        sa    = (a > 7) ? a - 16 : a;
        sb    = (b > 7) ? b - 16 : b;
        full  = 0;
        sfull = 0;
        carry = 1'b0;
        ovfl  = 1'b0;
        case (alu_op_e'(s[10:8]))
            OP_ADD: begin
                full  = a + b;
                sfull = sa + sb;
                carry = (full > 15);
                ovfl  = (sfull > 7) || (sfull < -8);
            end
            OP_SUB: begin
                full  = a - b;
                sfull = sa - sb;
                // no borrow reads as carry set
                carry = (a >= b);
                ovfl  = (sfull > 7) || (sfull < -8);
            end
            OP_NOT:  full = 15 - a;
            OP_AND:  full = int'(s[3:0] & s[7:4]);
            OP_OR:   full = int'(s[3:0] | s[7:4]);
            OP_XOR:  full = int'(s[3:0] ^ s[7:4]);
            OP_SLT:  full = (sa < sb) ? 1 : 0;
            default: full = (a == b) ? 1 : 0;
        endcase
        res = full[3:0];
        return {carry, ovfl, res == 4'd0, res};
    endfunction

    // ledr[12:0] in encode mode
    function automatic logic [12:0] enc_leds(input logic [15:0] s);
        logic [12:0] r;
        r = '0;
        if (s[8]) begin
            for (int i = 7; i >= 0; i--) begin
                if (s[i] && !r[4]) begin
                    r[2:0] = 3'(i);
                    r[4]   = 1'b1;
                end
            end
        end
        return r;
    endfunction

    assign exp_alu     = alu_leds(sw);
    assign exp_enc     = enc_leds(sw);
    assign exp_enc_seg = exp_enc[4] ? SEG_HEX[{1'b0, exp_enc[2:0]}] : SEG_BLANK;

    always @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            exp_mode    <= MODE_ALU;
            exp_pattern <= 8'h00;
        end else begin
            if (sw[15] && sw[14:12] <= 3'd2) begin
                exp_mode <= board_mode_e'(sw[14:12]);
            end
            // step sees the mode from before this edge
            if (exp_mode == MODE_SHIFT && !sw[15]) begin
                if (exp_pattern == 8'h00) begin
                    exp_pattern <= 8'h01;
                end else begin
                    exp_pattern <= (exp_pattern >> 1) | (exp_pattern << 7);
                end
            end
        end
    end

    mode_a: assert property (@(negedge btn) disable iff (!rst_n)
        ledr[15:13] == exp_mode)
        else report_mismatch($sformatf("mode field %0d, expected %0d",
                                       ledr[15:13], exp_mode));

    upper_blank_a: assert property (@(negedge btn) disable iff (!rst_n)
        segs[63:16] == {6{SEG_BLANK}})
        else report_mismatch($sformatf("digits 2 to 7 not blank: %h", segs[63:16]));

    alu_leds_a: assert property (@(negedge btn) disable iff (!rst_n)
        (exp_mode == MODE_ALU) |-> (ledr[12:0] == {6'd0, exp_alu}))
        else report_mismatch($sformatf("alu ledr %h, expected %h, sw %h",
                                       ledr[12:0], exp_alu, sw));

    alu_seg_a: assert property (@(negedge btn) disable iff (!rst_n)
        (exp_mode == MODE_ALU) |->
            (segs.seg0 == SEG_HEX[exp_alu[3:0]] && segs.seg1 == SEG_BLANK))
        else report_mismatch($sformatf("alu digits %h %h, sw %h",
                                       segs.seg1, segs.seg0, sw));

    enc_leds_a: assert property (@(negedge btn) disable iff (!rst_n)
        (exp_mode == MODE_ENCODE) |-> (ledr[12:0] == exp_enc))
        else report_mismatch($sformatf("encoder ledr %h, expected %h, sw %h",
                                       ledr[12:0], exp_enc, sw));

    enc_seg_a: assert property (@(negedge btn) disable iff (!rst_n)
        (exp_mode == MODE_ENCODE) |->
            (segs.seg0 == exp_enc_seg && segs.seg1 == SEG_BLANK))
        else report_mismatch($sformatf("encoder digits %h %h, expected %h",
                                       segs.seg1, segs.seg0, exp_enc_seg));

    shift_leds_a: assert property (@(negedge btn) disable iff (!rst_n)
        (exp_mode == MODE_SHIFT) |-> (ledr[12:0] == {5'd0, exp_pattern}))
        else report_mismatch($sformatf("pattern %h, expected %h",
                                       ledr[7:0], exp_pattern));

    shift_seg_a: assert property (@(negedge btn) disable iff (!rst_n)
        (exp_mode == MODE_SHIFT) |->
            (segs.seg0 == SEG_HEX[exp_pattern[3:0]] &&
             segs.seg1 == SEG_HEX[exp_pattern[7:4]]))
        else report_mismatch($sformatf("pattern digits %h %h for %h",
                                       segs.seg1, segs.seg0, exp_pattern));

    task automatic drive_sw(input logic [15:0] v);
        @(posedge btn);
        #5;
        sw = v;
    endtask

    task automatic load_mode(input logic [2:0] code);
        drive_sw({1'b1, code, 12'($urandom)});
    endtask

    task automatic wait_mode(input logic [2:0] code);
        int n;
        n = 0;
        while (ledr[15:13] != code) begin
            @(negedge btn);
            n++;
            if (n > 4) begin
                report_timeout($sformatf("mode %0d on ledr", code));
            end
        end
    endtask

    initial begin
        int unsigned seed_ret;
        logic [15:0] r;
        logic [7:0]  want;
        btn      = 1'b0;
        rst_n    = 1'b0;
        sw       = 16'h0000;
        seed_ret = $urandom(32'h111f_2427);
        repeat (4) @(posedge btn);
        #5;
        rst_n = 1'b1;

        @(negedge btn);
        assert (ledr[15:13] == 3'd0)
            else report_mismatch("mode after reset is not ALU");

        // shift mode with the strobe held, so no step yet
        drive_sw({1'b1, 3'd2, 12'h000});
        wait_mode(3'd2);
        drive_sw({1'b1, 3'd2, 12'h000});
        @(negedge btn);
        assert (ledr[7:0] == 8'h00 && segs.seg0 == SEG_HEX[0])
            else report_mismatch($sformatf("pattern %h before any step", ledr[7:0]));

        load_mode(3'd0);
        wait_mode(3'd0);
        for (int i = 0; i < 200; i++) begin
            r     = 16'($urandom);
            r[15] = 1'b0;
            drive_sw(r);
        end

        load_mode(3'd1);
        wait_mode(3'd1);
        for (int code = 3; code < 8; code++) begin
            load_mode(3'(code));
            @(negedge btn);
            @(negedge btn);
            assert (ledr[15:13] == 3'd1)
                else report_mismatch($sformatf("illegal code %0d changed mode", code));
        end

        drive_sw(16'h0100);
        drive_sw(16'h0000);
        for (int i = 0; i < 100; i++) begin
            r     = 16'($urandom);
            r[15] = 1'b0;
            r[8]  = i[0];
            drive_sw(r);
        end

        load_mode(3'd2);
        wait_mode(3'd2);
        r     = 16'($urandom);
        r[15] = 1'b0;
        drive_sw(r);
        for (int i = 0; i < 9; i++) begin
            want = (i == 0) ? 8'h01 : 8'h80 >> ((i - 1) % 8);
            @(posedge btn);
            @(negedge btn);
            assert (ledr[7:0] == want)
                else report_mismatch($sformatf("step %0d pattern %h, expected %h",
                                               i, ledr[7:0], want));
        end

        // strobe high blocks the step
        drive_sw({1'b1, 3'd2, 12'h000});
        @(negedge btn);
        assert (ledr[7:0] == 8'h80)
            else report_mismatch($sformatf("pattern %h, expected 80", ledr[7:0]));
        @(posedge btn);
        @(negedge btn);
        assert (ledr[7:0] == 8'h80)
            else report_mismatch("pattern stepped with strobe high");

        $display("Everything OK");
        $finish;
    end

endmodule

/* src/lab_board.sv */
`timescale 1ns/1ps

module lab_board (
    input  logic                 btn,
    input  logic                 rst_n,
    input  logic [15:0]          sw,
    output logic [15:0]          ledr,
    output board_pkg::seg_bank_t segs
);
    import board_pkg::*;
    import alu_pkg::*;

    board_mode_e          mode;
    logic [ALU_W-1:0]     alu_result;
    alu_flags_t           alu_flags;
    logic [2:0]           enc_index;
    logic                 enc_valid;
    logic [PATTERN_W-1:0] pattern;
    logic                 step;

    // no stepping while a mode load is strobed
    assign step = (mode == MODE_SHIFT) && !sw[15];

    mode_reg u_mode (
        .btn   (btn),
        .rst_n (rst_n),
        .sw    (sw),
        .mode  (mode)
    );

    alu4 u_alu (
        .a      (sw[3:0]),
        .b      (sw[7:4]),
        .op     (alu_op_e'(sw[10:8])),
        .result (alu_result),
        .flags  (alu_flags)
    );

    prio_encoder u_enc (
        .src   (sw[7:0]),
        .en    (sw[8]),
        .index (enc_index),
        .valid (enc_valid)
    );

    shift_rng u_shift (
        .btn     (btn),
        .rst_n   (rst_n),
        .step    (step),
        .pattern (pattern)
    );

    display_mux u_disp (
        .mode       (mode),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .enc_index  (enc_index),
        .enc_valid  (enc_valid),
        .pattern    (pattern),
        .ledr       (ledr),
        .segs       (segs)
    );

endmodule

/* src/display_mux.sv */
`timescale 1ns/1ps

module display_mux (
    input  board_pkg::board_mode_e           mode,
    input  logic [alu_pkg::ALU_W-1:0]        alu_result,
    input  alu_pkg::alu_flags_t              alu_flags,
    input  logic [2:0]                       enc_index,
    input  logic                             enc_valid,
    input  logic [board_pkg::PATTERN_W-1:0]  pattern,
    output logic [15:0]                      ledr,
    output board_pkg::seg_bank_t             segs
);
    import board_pkg::*;
    import alu_pkg::*;

    logic [3:0] dig0_value;
    logic       dig0_blank;
    logic [3:0] dig1_value;
    logic       dig1_blank;
    seg_t       dig0_seg;
    seg_t       dig1_seg;

    always_comb begin
        ledr       = '0;
        dig0_value = 4'd0;
        dig0_blank = 1'b1;
        dig1_value = 4'd0;
        dig1_blank = 1'b1;
        case (mode)
            MODE_ALU: begin
                ledr[ALU_W-1:0] = alu_result;
                ledr[4]         = alu_flags.zero;
                ledr[5]         = alu_flags.ovfl;
                ledr[6]         = alu_flags.carry;
                dig0_value      = alu_result;
                dig0_blank      = 1'b0;
            end
            MODE_ENCODE: begin
                ledr[2:0]  = enc_index;
                ledr[4]    = enc_valid;
                dig0_value = {1'b0, enc_index};
                // nothing to show without a set bit
                dig0_blank = !enc_valid;
            end
            MODE_SHIFT: begin
                ledr[PATTERN_W-1:0] = pattern;
                dig0_value          = pattern[3:0];
                dig0_blank          = 1'b0;
                dig1_value          = pattern[7:4];
                dig1_blank          = 1'b0;
            end
            default: begin
                dig0_blank = 1'b1;
            end
        endcase
        // mode code is always visible
        ledr[15:13] = mode;
    end

    seg_decoder u_dig0 (
        .value (dig0_value),
        .blank (dig0_blank),
        .seg   (dig0_seg)
    );

    seg_decoder u_dig1 (
        .value (dig1_value),
        .blank (dig1_blank),
        .seg   (dig1_seg)
    );

    always_comb begin
        segs.seg7 = SEG_BLANK;
        segs.seg6 = SEG_BLANK;
        segs.seg5 = SEG_BLANK;
        segs.seg4 = SEG_BLANK;
        segs.seg3 = SEG_BLANK;
        segs.seg2 = SEG_BLANK;
        segs.seg1 = dig1_seg;
        segs.seg0 = dig0_seg;
    end

endmodule

/* src/seg_decoder.sv */
`timescale 1ns/1ps

module seg_decoder (
    input  logic            [3:0] value,
    input  logic                  blank,
    output board_pkg::seg_t       seg
);
    import board_pkg::*;

    always_comb begin
        if (blank) begin
            seg = SEG_BLANK;
        end else begin
            seg = SEG_HEX[value];
        end
    end

endmodule

/* src/shift_rng.sv */
`timescale 1ns/1ps

module shift_rng (
    input  logic                           btn,
    input  logic                           rst_n,
    input  logic                           step,
    output logic [board_pkg::PATTERN_W-1:0] pattern
);
    import board_pkg::*;

    logic [PATTERN_W-1:0] next_pattern;

    // seed from zero, else rotate right
    always_comb begin
        if (pattern == '0) begin
            next_pattern = {{(PATTERN_W-1){1'b0}}, 1'b1};
        end else begin
            next_pattern = {pattern[0], pattern[PATTERN_W-1:1]};
        end
    end

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            pattern <= '0;
        end else if (step) begin
            pattern <= next_pattern;
        end
    end

    onehot_a: assert property (@(posedge btn) disable iff (!rst_n)
        (pattern != '0) |-> $onehot(pattern))
        else $error("shift_rng: pattern %h is not one-hot", pattern);

endmodule

/* src/prio_encoder.sv */
`timescale 1ns/1ps

module prio_encoder (
    input  logic [7:0] src,
    input  logic       en,
    output logic [2:0] index,
    output logic       valid
);

    logic [2:0] hi_bit;
    logic       any_set;

    // scan upward so the highest set bit wins
    always_comb begin
        hi_bit  = 3'd0;
        any_set = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (src[i]) begin
                hi_bit  = 3'(i);
                any_set = 1'b1;
            end
        end
    end

    always_comb begin
        if (en && any_set) begin
            index = hi_bit;
            valid = 1'b1;
        end else begin
            index = 3'd0;
            valid = 1'b0;
        end
    end

endmodule

/* src/alu4.sv */
`timescale 1ns/1ps

module alu4 (
    input  logic [alu_pkg::ALU_W-1:0] a,
    input  logic [alu_pkg::ALU_W-1:0] b,
    input  alu_pkg::alu_op_e          op,
    output logic [alu_pkg::ALU_W-1:0] result,
    output alu_pkg::alu_flags_t       flags
);
    import alu_pkg::*;

    logic [ALU_W-1:0] b_in;
    logic             cin;
    logic [ALU_W:0]   sum;
    logic             arith;
    logic             lt;

    // shared adder, subtract is a + ~b + 1
    always_comb begin
        arith = (op == OP_ADD) || (op == OP_SUB);
        b_in  = (op == OP_SUB) ? ~b : b;
        cin   = (op == OP_SUB);
        sum   = {1'b0, a} + {1'b0, b_in} + {{ALU_W{1'b0}}, cin};
        lt    = $signed(a) < $signed(b);
    end

    always_comb begin
        case (op)
            OP_ADD:  result = sum[ALU_W-1:0];
            OP_SUB:  result = sum[ALU_W-1:0];
            OP_NOT:  result = ~a;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLT:  result = {{(ALU_W-1){1'b0}}, lt};
            OP_EQ:   result = {{(ALU_W-1){1'b0}}, a == b};
            default: result = '0;
        endcase
    end

    always_comb begin
        flags.zero  = (result == '0);
        // carry out of the 5-bit add, so no borrow reads as 1
        flags.carry = arith & sum[ALU_W];
        // operands agree in sign, sum does not
        flags.ovfl  = arith & (a[ALU_W-1] == b_in[ALU_W-1])
                            & (sum[ALU_W-1] != a[ALU_W-1]);
    end

    always_comb begin
        if (op inside {OP_NOT, OP_AND, OP_OR, OP_XOR}) begin
            logic_flags_a: assert (!flags.carry && !flags.ovfl)
                else $error("alu4: arithmetic flag set for %s", op.name());
        end
    end

endmodule

/* src/mode_reg.sv */
`timescale 1ns/1ps

module mode_reg (
    input  logic                   btn,
    input  logic                   rst_n,
    input  logic [15:0]            sw,
    output board_pkg::board_mode_e mode
);
    import board_pkg::*;

    logic       load;
    logic [2:0] req;
    logic       req_legal;

    // strobe is a level, sampled on every button edge
    assign load = sw[15];
    assign req  = sw[14:12];

    always_comb begin
        case (req)
            MODE_ALU, MODE_ENCODE, MODE_SHIFT: req_legal = 1'b1;
            default: req_legal = 1'b0;
        endcase
    end

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_ALU;
        end else if (load && req_legal) begin
            mode <= board_mode_e'(req);
        end
    end

    mode_legal_a: assert property (@(posedge btn) disable iff (!rst_n)
        mode inside {MODE_ALU, MODE_ENCODE, MODE_SHIFT})
        else $error("mode_reg: illegal mode code %0d", mode);

endmodule

/* src/alu_pkg.sv */
package alu_pkg;

    localparam int ALU_W = 4;

    // opcode comes straight from sw[10:8]
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_NOT = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5,
        OP_SLT = 3'd6,
        OP_EQ  = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic zero;
        logic ovfl;
        logic carry;
    } alu_flags_t;

endpackage

/* src/board_pkg.sv */
package board_pkg;

    // experiment selected for the LEDs and digits
    typedef enum logic [2:0] {
        MODE_ALU    = 3'd0,
        MODE_ENCODE = 3'd1,
        MODE_SHIFT  = 3'd2
    } board_mode_e;

    // active low, bit 7 is the decimal point, bits 6..0 are g..a
    typedef logic [7:0] seg_t;

    typedef struct packed {
        seg_t seg7;
        seg_t seg6;
        seg_t seg5;
        seg_t seg4;
        seg_t seg3;
        seg_t seg2;
        seg_t seg1;
        seg_t seg0;
    } seg_bank_t;

    localparam seg_t SEG_BLANK = 8'hff;

    // hex digits 0..f, point off
    localparam seg_t SEG_HEX [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0,
        8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83,
        8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    localparam int PATTERN_W = 8;

endpackage
